//--- hdl/cps15_sdram_pkg.sv
// SDRAM bank view as seen by the ROM fetch logic; read only, fixed two-word bursts, 16-bit bus
package cps15_sdram_pkg;

    // Word address into one 4M x 16 bank
    localparam int BANK_AW = 22;

    // Width of one data word on data_read
    localparam int WORD_W = 16;

    typedef logic [BANK_AW-1:0] bank_addr_t;

    typedef logic [WORD_W-1:0] sdram_word_t;

    // Words returned for each ba_rd request
    // The last one always comes with ba_rdy
    localparam int BURST_WORDS = 2;

endpackage

//--- hdl/cps15_client_pkg.sv
// ROM client payload layouts and client indices; payload widths must be whole 16-bit words
package cps15_client_pkg;

    // Graphics payload, two bank words
    // Word 0 sits in bits 15:0, word 1 in bits 31:16
    typedef logic [31:0] gfx_data_t;

    // Sound payload, word 0 of the burst only
    typedef logic [15:0] snd_data_t;

    // Index of a client on the shared bank
    typedef enum logic {
        CLIENT_GFX = 1'b0,
        CLIENT_SND = 1'b1
    } client_id_t;

endpackage

//--- hdl/cps15_rom_slot.sv
// One-entry ROM cache per client; payload_t must be a multiple of 16 bits, no more than BURST_WORDS words
`timescale 1ns/1ps

module cps15_rom_slot
    import cps15_sdram_pkg::*;
#(
    parameter int  AW        = 20,
    parameter type payload_t = logic [31:0]
) (
    input  logic          clk,
    input  logic          reset,
    // Client side
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic          ok,
    output payload_t      data,
    // Arbiter side
    output logic          req,
    output logic [AW-1:0] req_addr,
    input  logic          word_ok,
    input  logic          fill_done,
    input  sdram_word_t   data_read
);

    localparam int PW     = $bits(payload_t);
    localparam int SW     = $bits(sdram_word_t);
    localparam int HALVES = PW / SW;
    localparam int CW     = $clog2(HALVES + 1);

    logic             valid;
    logic [AW-1:0]    tag;
    logic [PW-1:0]    payload_q;
    logic [PW+SW-1:0] shift_in;
    logic [CW-1:0]    word_cnt;
    logic             hit;
    logic             miss;
    logic             take;

    assign hit  = valid && (tag == addr);
    assign miss = cs && !hit && !req;

    // Answer straight from the entry, no wait on a hit
    assign ok   = cs && hit;
    assign data = payload_t'(payload_q);

    // New words enter at the top and move down, so word 0 ends up lowest
    assign shift_in = {data_read, payload_q};

    // Words past the payload size are dropped
    assign take = word_ok && (word_cnt < CW'(HALVES));

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= 1'b0;
            req      <= 1'b0;
            word_cnt <= '0;
        end else if (req) begin
            if (take) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (fill_done) begin
                valid <= 1'b1;
                req   <= 1'b0;
            end
        end else if (miss) begin
            // Entry is overwritten during the fill, so drop it now
            valid    <= 1'b0;
            req      <= 1'b1;
            word_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            req_addr <= addr;
        end
        if (req && take) begin
            payload_q <= shift_in[PW+SW-1:SW];
        end
        if (req && fill_done) begin
            tag <= req_addr;
        end
    end

endmodule

//--- hdl/cps15_bank_arbiter.sv
// Two-client read arbiter for one SDRAM bank; one burst in flight, no writes, sound region at SND_OFFSET
`timescale 1ns/1ps

module cps15_bank_arbiter
    import cps15_sdram_pkg::*, cps15_client_pkg::*;
#(
    parameter int         GFX_AW     = 20,
    parameter int         SND_AW     = 19,
    parameter bank_addr_t SND_OFFSET = 22'h200000
) (
    input  logic              clk,
    input  logic              reset,
    // Slot side
    input  logic              gfx_req,
    input  logic [GFX_AW-1:0] gfx_addr,
    input  logic              snd_req,
    input  logic [SND_AW-1:0] snd_addr,
    output logic              gfx_word_ok,
    output logic              gfx_fill_done,
    output logic              snd_word_ok,
    output logic              snd_fill_done,
    // Bank side
    output bank_addr_t        ba_addr,
    output logic              ba_rd,
    input  logic              ba_ack,
    input  logic              ba_dok,
    input  logic              ba_rdy
);

    localparam int CW = $clog2(BURST_WORDS + 1);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        RECV
    } state_t;

    state_t     state;
    client_id_t grant;
    client_id_t next_grant;
    logic [CW-1:0] word_cnt;
    logic       word_take;
    logic       last_word;

    // Round robin: grant holds whoever was served last
    always_comb begin
        if (gfx_req && snd_req) begin
            next_grant = (grant == CLIENT_GFX) ? CLIENT_SND : CLIENT_GFX;
        end else if (snd_req) begin
            next_grant = CLIENT_SND;
        end else begin
            next_grant = CLIENT_GFX;
        end
    end

    assign ba_rd = (state == WAIT_ACK);

    // Extra dok pulses beyond the burst length are not forwarded
    assign word_take = (state == RECV) && ba_dok && (word_cnt < CW'(BURST_WORDS));
    assign last_word = word_take && ba_rdy;

    assign gfx_word_ok   = word_take && (grant == CLIENT_GFX);
    assign snd_word_ok   = word_take && (grant == CLIENT_SND);
    assign gfx_fill_done = last_word && (grant == CLIENT_GFX);
    assign snd_fill_done = last_word && (grant == CLIENT_SND);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            grant    <= CLIENT_SND;
            word_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (gfx_req || snd_req) begin
                        grant <= next_grant;
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (ba_ack) begin
                        word_cnt <= '0;
                        state    <= RECV;
                    end
                end
                RECV: begin
                    if (word_take) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_word) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Bank address is captured with the grant and held through the burst
    always_ff @(posedge clk) begin
        if (state == IDLE && (gfx_req || snd_req)) begin
            if (next_grant == CLIENT_GFX) begin
                ba_addr <= bank_addr_t'(gfx_addr);
            end else begin
                ba_addr <= bank_addr_t'(snd_addr) + SND_OFFSET;
            end
        end
    end

endmodule

//--- hdl/cps15_rom_fetch.sv
// Graphics and sound ROM fetch on one SDRAM bank; single clock, sound ROM must fit above SND_OFFSET
`timescale 1ns/1ps

module cps15_rom_fetch
    import cps15_sdram_pkg::*, cps15_client_pkg::*;
#(
    parameter int         GFX_AW     = 20,
    parameter int         SND_AW     = 19,
    parameter bank_addr_t SND_OFFSET = 22'h200000
) (
    input  logic              clk,
    input  logic              reset,
    // Graphics ROM client
    input  logic              gfx_cs,
    input  logic [GFX_AW-1:0] gfx_addr,
    output logic              gfx_ok,
    output gfx_data_t         gfx_data,
    // Sound ROM client
    input  logic              snd_cs,
    input  logic [SND_AW-1:0] snd_addr,
    output logic              snd_ok,
    output snd_data_t         snd_data,
    // SDRAM bank
    output bank_addr_t        ba_addr,
    output logic              ba_rd,
    input  logic              ba_ack,
    input  logic              ba_dok,
    input  logic              ba_rdy,
    input  sdram_word_t       data_read
);

    logic              gfx_req;
    logic [GFX_AW-1:0] gfx_req_addr;
    logic              gfx_word_ok;
    logic              gfx_fill_done;
    logic              snd_req;
    logic [SND_AW-1:0] snd_req_addr;
    logic              snd_word_ok;
    logic              snd_fill_done;

    cps15_rom_slot #(
        .AW        ( GFX_AW     ),
        .payload_t ( gfx_data_t )
    ) u_gfx_slot (
        .clk       ( clk           ),
        .reset     ( reset         ),
        .cs        ( gfx_cs        ),
        .addr      ( gfx_addr      ),
        .ok        ( gfx_ok        ),
        .data      ( gfx_data      ),
        .req       ( gfx_req       ),
        .req_addr  ( gfx_req_addr  ),
        .word_ok   ( gfx_word_ok   ),
        .fill_done ( gfx_fill_done ),
        .data_read ( data_read     )
    );

    // Sound keeps word 0 only, the second burst word is dropped in the slot
    cps15_rom_slot #(
        .AW        ( SND_AW     ),
        .payload_t ( snd_data_t )
    ) u_snd_slot (
        .clk       ( clk           ),
        .reset     ( reset         ),
        .cs        ( snd_cs        ),
        .addr      ( snd_addr      ),
        .ok        ( snd_ok        ),
        .data      ( snd_data      ),
        .req       ( snd_req       ),
        .req_addr  ( snd_req_addr  ),
        .word_ok   ( snd_word_ok   ),
        .fill_done ( snd_fill_done ),
        .data_read ( data_read     )
    );

    cps15_bank_arbiter #(
        .GFX_AW     ( GFX_AW     ),
        .SND_AW     ( SND_AW     ),
        .SND_OFFSET ( SND_OFFSET )
    ) u_arbiter (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .gfx_req       ( gfx_req       ),
        .gfx_addr      ( gfx_req_addr  ),
        .snd_req       ( snd_req       ),
        .snd_addr      ( snd_req_addr  ),
        .gfx_word_ok   ( gfx_word_ok   ),
        .gfx_fill_done ( gfx_fill_done ),
        .snd_word_ok   ( snd_word_ok   ),
        .snd_fill_done ( snd_fill_done ),
        .ba_addr       ( ba_addr       ),
        .ba_rd         ( ba_rd         ),
        .ba_ack        ( ba_ack        ),
        .ba_dok        ( ba_dok        ),
        .ba_rdy        ( ba_rdy        )
    );

endmodule

//--- testbench/sdram_bank_model.sv
// Read-only SDRAM bank model; one burst at a time, contents follow a fixed address rule, no refresh
`timescale 1ns/1ps

module sdram_bank_model
    import cps15_sdram_pkg::*;
#(
    parameter int MAX_ACK_DELAY = 4,
    parameter int MAX_GAP       = 2
) (
    input  logic        clk,
    input  logic        ba_rd,
    input  bank_addr_t  ba_addr,
    output logic        ba_ack,
    output logic        ba_dok,
    output logic        ba_rdy,
    output sdram_word_t data_read
);

    // Word k at address A: low half of 2A+k, upper bits folded in, then scrambled
    function automatic sdram_word_t word_at(input bank_addr_t a, input int k);
        logic [BANK_AW:0] s;
        s = {a, 1'b0} + (BANK_AW+1)'(k);
        return s[15:0] ^ 16'(s[BANK_AW:16]) ^ 16'hC95A;
    endfunction

    // All outputs change on the falling edge only
    initial begin
        bank_addr_t a;
        int         delay;
        int         gap;
        ba_ack    = 1'b0;
        ba_dok    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (ba_rd) begin
                a     = ba_addr;
                delay = $urandom_range(1, MAX_ACK_DELAY);
                repeat (delay - 1) @(negedge clk);
                ba_ack = 1'b1;
                @(negedge clk);
                ba_ack = 1'b0;
                for (int k = 0; k < BURST_WORDS; k++) begin
                    gap = $urandom_range(0, MAX_GAP);
                    repeat (gap) @(negedge clk);
                    ba_dok    = 1'b1;
                    // rdy marks the last word of the burst
                    ba_rdy    = (k == BURST_WORDS - 1);
                    data_read = word_at(a, k);
                    @(negedge clk);
                    ba_dok = 1'b0;
                    ba_rdy = 1'b0;
                end
            end
        end
    end

endmodule

//--- testbench/tb_cps15_rom_fetch.sv
// ROM fetch testbench; clients hold cs and addr steady until ok and the bank model answers every ba_rd
`timescale 1ns/1ps

module tb_cps15_rom_fetch
    import cps15_sdram_pkg::*, cps15_client_pkg::*;
();

    localparam int         GFX_AW          = 20;
    localparam int         SND_AW          = 19;
    localparam bank_addr_t SND_OFFSET      = 22'h200000;
    localparam int         RESET_CYCLES    = 10;
    localparam int         PAIR_ROUNDS     = 4;
    localparam int         RANDOM_FETCHES  = 40;
    localparam int         FETCH_LIMIT     = 200;
    localparam int         NUM_FETCHES     = 2 + 2 * PAIR_ROUNDS + PAIR_ROUNDS / 2
                                             + 2 * RANDOM_FETCHES;
    localparam int         WATCHDOG_CYCLES = NUM_FETCHES * FETCH_LIMIT + 100;

    typedef logic [GFX_AW-1:0] gfx_addr_t;
    typedef logic [SND_AW-1:0] snd_addr_t;

    logic        clk;
    logic        reset;
    logic        gfx_cs;
    gfx_addr_t   gfx_addr;
    logic        gfx_ok;
    gfx_data_t   gfx_data;
    logic        snd_cs;
    snd_addr_t   snd_addr;
    logic        snd_ok;
    snd_data_t   snd_data;
    bank_addr_t  ba_addr;
    logic        ba_rd;
    logic        ba_ack;
    logic        ba_dok;
    logic        ba_rdy;
    sdram_word_t data_read;

    int          errors = 0;
    int          timeouts = 0;
    logic        hit_check;
    logic        cs_seen;
    logic        gfx_wait;
    logic        snd_wait;
    bank_addr_t  gfx_bank;
    bank_addr_t  snd_bank;
    gfx_data_t   gfx_exp;
    snd_data_t   snd_exp;
    client_id_t  ack_client;
    client_id_t  last_client;
    logic        gfx_cs_q;
    logic        snd_cs_q;
    logic        contended;

    cps15_rom_fetch #(
        .GFX_AW     ( GFX_AW     ),
        .SND_AW     ( SND_AW     ),
        .SND_OFFSET ( SND_OFFSET )
    ) DUT (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .gfx_cs    ( gfx_cs    ),
        .gfx_addr  ( gfx_addr  ),
        .gfx_ok    ( gfx_ok    ),
        .gfx_data  ( gfx_data  ),
        .snd_cs    ( snd_cs    ),
        .snd_addr  ( snd_addr  ),
        .snd_ok    ( snd_ok    ),
        .snd_data  ( snd_data  ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_dok    ( ba_dok    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    sdram_bank_model u_bank (
        .clk       ( clk       ),
        .ba_rd     ( ba_rd     ),
        .ba_addr   ( ba_addr   ),
        .ba_ack    ( ba_ack    ),
        .ba_dok    ( ba_dok    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected ROM word is 2A+k with its upper bits folded into the low half and XOR C95A
    function automatic sdram_word_t rom_word(input bank_addr_t a, input int k);
        logic [22:0] twice;
        twice = {a, 1'b0} + 23'(k);
        return twice[15:0] ^ {9'd0, twice[22:16]} ^ 16'hC95A;
    endfunction

    function automatic gfx_addr_t random_gfx_addr();
        // Half the picks from a small pool so that hits happen
        if ($urandom_range(0, 1) == 0) begin
            return gfx_addr_t'($urandom_range(0, 7));
        end
        return gfx_addr_t'($urandom);
    endfunction

    function automatic snd_addr_t random_snd_addr();
        if ($urandom_range(0, 1) == 0) begin
            return snd_addr_t'($urandom_range(0, 7));
        end
        return snd_addr_t'($urandom);
    endfunction

    assign gfx_bank   = bank_addr_t'(gfx_addr);
    assign snd_bank   = bank_addr_t'(snd_addr) + SND_OFFSET;
    assign gfx_exp    = {rom_word(gfx_bank, 1), rom_word(gfx_bank, 0)};
    assign snd_exp    = rom_word(snd_bank, 0);
    assign gfx_wait   = gfx_cs && !gfx_ok;
    assign snd_wait   = snd_cs && !snd_ok;
    assign ack_client = (ba_addr >= SND_OFFSET) ? CLIENT_SND : CLIENT_GFX;

    // Grant order bookkeeping updated on each accepted bank request
    always_ff @(posedge clk) begin
        if (reset) begin
            cs_seen     <= 1'b0;
            gfx_cs_q    <= 1'b0;
            snd_cs_q    <= 1'b0;
            contended   <= 1'b0;
            last_client <= CLIENT_GFX;
        end else begin
            gfx_cs_q <= gfx_cs;
            snd_cs_q <= snd_cs;
            if (gfx_cs || snd_cs) begin
                cs_seen <= 1'b1;
            end
            // Both clients start a miss in the same cycle while the bank is idle
            if (gfx_wait && snd_wait && !gfx_cs_q && !snd_cs_q) begin
                contended <= 1'b1;
            end else if (ba_rd && ba_ack) begin
                contended <= 1'b0;
            end
            if (ba_rd && ba_ack) begin
                last_client <= ack_client;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !cs_seen |-> !ba_rd && !gfx_ok && !snd_ok)
    else begin
        errors++;
        $display("ERROR %0t ba_rd/gfx_ok/snd_ok expected 000 got %b%b%b", $time,
                 $sampled(ba_rd), $sampled(gfx_ok), $sampled(snd_ok));
    end

    gfx_data_match: assert property (@(posedge clk) disable iff (reset)
        gfx_ok |-> gfx_data == gfx_exp)
    else begin
        errors++;
        $display("ERROR %0t gfx_data expected %h got %h", $time,
                 $sampled(gfx_exp), $sampled(gfx_data));
    end

    snd_data_match: assert property (@(posedge clk) disable iff (reset)
        snd_ok |-> snd_data == snd_exp)
    else begin
        errors++;
        $display("ERROR %0t snd_data expected %h got %h", $time,
                 $sampled(snd_exp), $sampled(snd_data));
    end

    // Sound requests must land in the offset region
    bank_addr_owned: assert property (@(posedge clk) disable iff (reset)
        ba_rd |-> (gfx_wait && ba_addr == gfx_bank) ||
                  (snd_wait && ba_addr == snd_bank && ba_addr >= SND_OFFSET))
    else begin
        errors++;
        $display("ERROR %0t ba_addr expected %h or %h got %h", $time,
                 $sampled(gfx_bank), $sampled(snd_bank), $sampled(ba_addr));
    end

    repeat_hits: assert property (@(posedge clk) disable iff (reset)
        hit_check |-> gfx_ok && snd_ok && !ba_rd)
    else begin
        errors++;
        $display("ERROR %0t gfx_ok/snd_ok/ba_rd expected 110 got %b%b%b", $time,
                 $sampled(gfx_ok), $sampled(snd_ok), $sampled(ba_rd));
    end

    // A tie goes to the client that was not served last
    alternate_grants: assert property (@(posedge clk) disable iff (reset)
        ba_rd && ba_ack && contended |-> ack_client != last_client)
    else begin
        errors++;
        $display("%0t: both clients missed together and the bank served the last client again",
                 $time);
    end

    task automatic gfx_fetch(input gfx_addr_t a, input int hold);
        int waited;
        @(negedge clk);
        gfx_cs   = 1'b1;
        gfx_addr = a;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!gfx_ok && waited < FETCH_LIMIT);
        if (!gfx_ok) begin
            timeouts++;
            $display("%0t: graphics fetch of %h never got ok", $time, a);
        end
        repeat (hold) @(posedge clk);
        @(negedge clk);
        gfx_cs = 1'b0;
    endtask

    task automatic snd_fetch(input snd_addr_t a, input int hold);
        int waited;
        @(negedge clk);
        snd_cs   = 1'b1;
        snd_addr = a;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!snd_ok && waited < FETCH_LIMIT);
        if (!snd_ok) begin
            timeouts++;
            $display("%0t: sound fetch of %h never got ok", $time, a);
        end
        repeat (hold) @(posedge clk);
        @(negedge clk);
        snd_cs = 1'b0;
    endtask

    initial begin
        gfx_addr_t ga;
        snd_addr_t sa;
        void'($urandom(9));
        reset     = 1'b1;
        hit_check = 1'b0;
        gfx_cs    = 1'b0;
        gfx_addr  = '0;
        snd_cs    = 1'b0;
        snd_addr  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // Idle window where bank and clients stay quiet
        repeat (5) @(negedge clk);

        ga = gfx_addr_t'($urandom);
        sa = snd_addr_t'($urandom);
        gfx_fetch(ga, 1);
        snd_fetch(sa, 1);

        // Same addresses again so both hit at once
        @(negedge clk);
        hit_check = 1'b1;
        gfx_cs    = 1'b1;
        gfx_addr  = ga;
        snd_cs    = 1'b1;
        snd_addr  = sa;
        repeat (3) @(negedge clk);
        hit_check = 1'b0;
        gfx_cs    = 1'b0;
        snd_cs    = 1'b0;

        // Both clients miss in the same cycle
        for (int r = 0; r < PAIR_ROUNDS; r++) begin
            // Odd rounds follow a graphics fetch so the tie must go to sound
            if (r % 2 == 1) begin
                gfx_fetch(gfx_addr_t'($urandom), 0);
            end
            fork
                gfx_fetch(gfx_addr_t'($urandom), 0);
                snd_fetch(snd_addr_t'($urandom), 0);
            join
        end

        fork
            for (int i = 0; i < RANDOM_FETCHES; i++) begin
                gfx_fetch(random_gfx_addr(), $urandom_range(0, 3));
            end
            for (int i = 0; i < RANDOM_FETCHES; i++) begin
                snd_fetch(random_snd_addr(), $urandom_range(0, 3));
            end
        join

        repeat (5) @(negedge clk);
        $display("Run complete: %0d check errors, %0d fetch timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with fetches still running", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- cps15_rom_fetch.f
hdl/cps15_sdram_pkg.sv
hdl/cps15_client_pkg.sv
hdl/cps15_rom_slot.sv
hdl/cps15_bank_arbiter.sv
hdl/cps15_rom_fetch.sv
testbench/sdram_bank_model.sv
testbench/tb_cps15_rom_fetch.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ROM fetch testbench with Verilator; the log decides pass or fail

TOP=tb_cps15_rom_fetch
BUILD_LOG=build.log
SIM_LOG=sim.log

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert --top-module "$TOP" -f cps15_rom_fetch.f -o "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
